//--- common/core_pkg.sv
package core_pkg;

    // Data path and address width
    localparam int xlen = 32;

    // Register index width
    localparam int reg_addr_w = 5;

    // Address of the first fetch
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    // Supported major opcodes
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111
    } opcode_t;

    // ALU operations
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_slt = 3'd5
    } alu_op_t;

    // Immediate formats
    typedef enum logic [2:0] {
        imm_i = 3'd0,
        imm_s = 3'd1,
        imm_b = 3'd2,
        imm_u = 3'd3,
        imm_j = 3'd4
    } imm_fmt_t;

    // Register writeback source
    typedef enum logic [1:0] {
        wb_alu   = 2'd0,
        wb_load  = 2'd1,
        wb_pc4   = 2'd2,
        wb_upper = 2'd3
    } wb_src_t;

    // Next pc source
    typedef enum logic [1:0] {
        pc_seq = 2'd0,
        pc_rel = 2'd1,
        pc_reg = 2'd2
    } pc_src_t;

endpackage

//--- common/data_req_if.sv
`timescale 1ns/10ps

interface data_req_if import core_pkg::*; ();

    // Request side, held for the whole load or store
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic            read;
    logic            write;

    // Response side, rdata valid in the cycle busy drops
    logic [xlen-1:0] rdata;
    logic            busy;

    modport requester (
        output addr, wdata, read, write,
        input  rdata, busy
    );

    modport completer (
        input  addr, wdata, read, write,
        output rdata, busy
    );

endinterface

//--- core/alu.sv
`timescale 1ns/10ps

module alu import core_pkg::*; (
    input  alu_op_t         op,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] result,
    output logic            zero,
    output logic            lt
);

    // Signed compare, shared by slt and the branch decision
    assign lt = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            alu_slt: result = {{(xlen-1){1'b0}}, lt};
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- core/regfile.sv
`timescale 1ns/10ps

module regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    input  logic [4:0]  waddr,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [31:0] wdata
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

//--- core/control_decoder.sv
`timescale 1ns/10ps

module control_decoder import core_pkg::*; (
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    input  logic       alu_zero,
    input  logic       alu_lt,
    output alu_op_t    alu_op,
    output imm_fmt_t   imm_fmt,
    output logic       alu_use_imm,
    output logic       reg_write,
    output logic       mem_read,
    output logic       mem_write,
    output wb_src_t    wb_src,
    output pc_src_t    pc_src
);

    logic branch_taken;

    // beq, bne, plus blt and bge from the signed compare
    always_comb begin
        case (funct3)
            3'b000:  branch_taken = alu_zero;
            3'b001:  branch_taken = ~alu_zero;
            3'b100:  branch_taken = alu_lt;
            3'b101:  branch_taken = ~alu_lt;
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        // Safe defaults, also used for anything unsupported
        alu_op      = alu_add;
        imm_fmt     = imm_i;
        alu_use_imm = 1'b0;
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        wb_src      = wb_alu;
        pc_src      = pc_seq;

        case (opcode_t'(opcode))
            opc_op: begin
                if (funct7 == 7'h00 || (funct7 == 7'h20 && funct3 == 3'b000)) begin
                    reg_write = 1'b1;
                end
                case (funct3)
                    3'b000:  alu_op = funct7[5] ? alu_sub : alu_add;
                    3'b010:  alu_op = alu_slt;
                    3'b100:  alu_op = alu_xor;
                    3'b110:  alu_op = alu_or;
                    3'b111:  alu_op = alu_and;
                    default: reg_write = 1'b0;
                endcase
            end
            opc_op_imm: begin
                alu_use_imm = 1'b1;
                reg_write   = 1'b1;
                case (funct3)
                    3'b000:  alu_op = alu_add;
                    3'b010:  alu_op = alu_slt;
                    3'b100:  alu_op = alu_xor;
                    3'b110:  alu_op = alu_or;
                    3'b111:  alu_op = alu_and;
                    // Shifts and sltiu are not implemented
                    default: reg_write = 1'b0;
                endcase
            end
            opc_lui: begin
                imm_fmt   = imm_u;
                wb_src    = wb_upper;
                reg_write = 1'b1;
            end
            opc_load: begin
                alu_use_imm = 1'b1;
                wb_src      = wb_load;
                // Word loads only
                reg_write   = (funct3 == 3'b010);
                mem_read    = (funct3 == 3'b010);
            end
            opc_store: begin
                imm_fmt     = imm_s;
                alu_use_imm = 1'b1;
                mem_write   = (funct3 == 3'b010);
            end
            opc_branch: begin
                imm_fmt = imm_b;
                alu_op  = alu_sub;
                pc_src  = branch_taken ? pc_rel : pc_seq;
            end
            opc_jal: begin
                imm_fmt   = imm_j;
                wb_src    = wb_pc4;
                reg_write = 1'b1;
                pc_src    = pc_rel;
            end
            opc_jalr: begin
                if (funct3 == 3'b000) begin
                    wb_src    = wb_pc4;
                    reg_write = 1'b1;
                    pc_src    = pc_reg;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

//--- core/datapath.sv
`timescale 1ns/10ps

module datapath import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [xlen-1:0] instr,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] pc_plus_four,
    output pc_src_t         pc_src,
    output logic [xlen-1:0] pc_target,
    output logic [xlen-1:0] jalr_target,
    data_req_if.requester   mem
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;

    alu_op_t         alu_op;
    imm_fmt_t        imm_fmt;
    wb_src_t         wb_src;
    logic            alu_use_imm;
    logic            reg_write;
    logic            mem_read;
    logic            mem_write;
    logic            alu_zero;
    logic            alu_lt;

    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] wb_data;

    // Instruction fields
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    // Immediate generation
    always_comb begin
        case (imm_fmt)
            imm_s:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            imm_b:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            imm_u:   imm = {instr[31:12], 12'b0};
            imm_j:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            default: imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    control_decoder control_decoder_inst (
        .opcode      (opcode),
        .funct3      (funct3),
        .funct7      (funct7),
        .alu_zero    (alu_zero),
        .alu_lt      (alu_lt),
        .alu_op      (alu_op),
        .imm_fmt     (imm_fmt),
        .alu_use_imm (alu_use_imm),
        .reg_write   (reg_write),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .wb_src      (wb_src),
        .pc_src      (pc_src)
    );

    // Writeback source
    always_comb begin
        case (wb_src)
            wb_load:  wb_data = mem.rdata;
            wb_pc4:   wb_data = pc_plus_four;
            wb_upper: wb_data = imm;
            default:  wb_data = alu_result;
        endcase
    end

    // A load only writes once its data has arrived
    regfile regfile_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .waddr  (rd),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data),
        .we     (reg_write & ~mem.busy),
        .wdata  (wb_data)
    );

    assign alu_b = alu_use_imm ? imm : rs2_data;

    alu alu_inst (
        .op     (alu_op),
        .a      (rs1_data),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero),
        .lt     (alu_lt)
    );

    // Branch and jump targets
    assign pc_target   = pc + imm;
    assign jalr_target = rs1_data + imm;

    // Word request, address from the ALU adder
    assign mem.addr  = alu_result;
    assign mem.wdata = rs2_data;
    assign mem.read  = mem_read;
    assign mem.write = mem_write;

endmodule

//--- verilog/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  pc_src_t         pc_src,
    input  logic [xlen-1:0] pc_target,
    input  logic [xlen-1:0] jalr_target,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] pc_plus_four
);

    logic [xlen-1:0] pc_next;

    assign pc_plus_four = pc + 32'd4;

    // Next address selection
    always_comb begin
        case (pc_src)
            pc_rel:  pc_next = pc_target;
            // jalr target always lands on an even address
            pc_reg:  pc_next = {jalr_target[xlen-1:1], 1'b0};
            default: pc_next = pc_plus_four;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

endmodule

//--- verilog/apb_data_master.sv
`timescale 1ns/10ps

module apb_data_master import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    data_req_if.completer   req,
    output logic [xlen-1:0] paddr,
    output logic            psel,
    output logic            penable,
    output logic            pwrite,
    output logic [xlen-1:0] pwdata,
    output logic [3:0]      pstrb,
    input  logic [xlen-1:0] prdata,
    input  logic            pready,
    input  logic            pslverr
);

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_access
    } apb_state_t;

    apb_state_t state;
    apb_state_t state_next;
    logic       req_valid;

    assign req_valid = req.read | req.write;

    always_comb begin
        state_next = state;
        case (state)
            st_idle:   if (req_valid) state_next = st_setup;
            st_setup:  state_next = st_access;
            st_access: if (pready) state_next = st_idle;
            default:   state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // Capture the transfer as it leaves idle
    always_ff @(posedge clk) begin
        if (state == st_idle && req_valid) begin
            paddr  <= req.addr;
            pwdata <= req.wdata;
            pwrite <= req.write;
        end
    end

    assign psel    = (state != st_idle);
    assign penable = (state == st_access);
    assign pstrb   = pwrite ? 4'hf : 4'h0;

    // Core stalls from the request cycle until pready
    always_comb begin
        case (state)
            st_idle:   req.busy = req_valid;
            st_setup:  req.busy = 1'b1;
            default:   req.busy = ~pready;
        endcase
    end

    // Slave errors are not reported back to the core
    assign req.rdata = prdata;

endmodule

//--- verilog/rv_core_top.sv
`timescale 1ns/10ps

module rv_core_top import core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] instr_addr,
    input  logic [31:0] instr_data,
    output logic [31:0] paddr,
    output logic        psel,
    output logic        penable,
    output logic        pwrite,
    output logic [31:0] pwdata,
    output logic [3:0]  pstrb,
    input  logic [31:0] prdata,
    input  logic        pready,
    input  logic        pslverr
);

    pc_src_t         pc_src;
    logic [xlen-1:0] pc_target;
    logic [xlen-1:0] jalr_target;
    logic [xlen-1:0] pc_plus_four;

    // Load and store requests towards the APB side
    data_req_if data_req ();

    // Program counter, held while a data transfer is pending
    fetch_unit fetch_unit_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (data_req.busy),
        .pc_src       (pc_src),
        .pc_target    (pc_target),
        .jalr_target  (jalr_target),
        .pc           (instr_addr),
        .pc_plus_four (pc_plus_four)
    );

    datapath datapath_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr        (instr_data),
        .pc           (instr_addr),
        .pc_plus_four (pc_plus_four),
        .pc_src       (pc_src),
        .pc_target    (pc_target),
        .jalr_target  (jalr_target),
        .mem          (data_req.requester)
    );

    apb_data_master apb_data_master_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (data_req.completer),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

endmodule

//--- verification/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// Test program for the core and an instruction-level model that predicts its stores

localparam int prog_len = 45;

localparam logic [31:0] op_imm_code  = 32'h13;
localparam logic [31:0] op_load_code = 32'h03;
localparam logic [31:0] op_jalr_code = 32'h67;

logic [31:0] prog [0:63];

// RV32I instruction encoders
function automatic logic [31:0] enc_r(input logic [31:0] f7, rs2, rs1, f3, rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [31:0] imm, rs1, f3, rd, opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
endfunction

function automatic logic [31:0] enc_s(input logic [31:0] imm, rs2, rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [31:0] imm, rs2, rs1, f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_u(input logic [31:0] imm20, rd);
    return {imm20[19:0], rd[4:0], 7'b0110111};
endfunction

function automatic logic [31:0] enc_j(input logic [31:0] imm, rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
endfunction

task automatic load_program();
    // Unused words hold an unsupported opcode
    for (int i = 0; i < 64; i++) begin
        prog[i] = {i[24:0], 7'h7f};
    end
    // ALU results
    prog[0]  = enc_u(32'hfedcb, 1);
    prog[1]  = enc_i(-7, 0, 0, 2, op_imm_code);
    prog[2]  = enc_i(5, 0, 0, 3, op_imm_code);
    prog[3]  = enc_r(32, 2, 3, 0, 4);
    prog[4]  = enc_r(0, 3, 2, 2, 5);
    prog[5]  = enc_r(0, 2, 1, 0, 6);
    prog[6]  = enc_i(240, 2, 4, 7, op_imm_code);
    prog[7]  = enc_r(0, 2, 1, 7, 8);
    prog[8]  = enc_r(0, 3, 7, 6, 9);
    prog[9]  = enc_i(-3, 2, 2, 10, op_imm_code);
    prog[10] = enc_i(-256, 1, 7, 11, op_imm_code);
    prog[11] = enc_i(1365, 2, 6, 12, op_imm_code);
    prog[12] = enc_r(0, 2, 1, 4, 13);
    // Store x1 and x4 to x13 from 0x80 upwards
    prog[13] = enc_s(32'h80, 1, 0);
    for (int i = 0; i < 10; i++) begin
        prog[14 + i] = enc_s(32'h84 + 4 * i, 4 + i, 0);
    end
    // Loads, one of them reading back an earlier store
    prog[24] = enc_i(32'h10, 0, 2, 14, op_load_code);
    prog[25] = enc_i(32'h123, 14, 0, 15, op_imm_code);
    prog[26] = enc_s(32'hac, 15, 0);
    prog[27] = enc_i(32'h84, 0, 2, 16, op_load_code);
    prog[28] = enc_r(0, 14, 16, 0, 16);
    prog[29] = enc_s(32'hb0, 16, 0);
    // Write to x0, then store it
    prog[30] = enc_i(55, 0, 0, 0, op_imm_code);
    prog[31] = enc_s(32'hb4, 0, 0);
    // Branches, each skipped store would show up as extra
    prog[32] = enc_b(8, 3, 3, 0);
    prog[33] = enc_s(32'hb8, 1, 0);
    prog[34] = enc_b(8, 3, 3, 1);
    prog[35] = enc_b(8, 3, 2, 1);
    prog[36] = enc_s(32'hbc, 2, 0);
    prog[37] = enc_b(8, 3, 2, 0);
    // Jumps and their link values
    prog[38] = enc_j(8, 17);
    prog[39] = enc_s(32'hc0, 1, 0);
    prog[40] = enc_s(32'hc4, 17, 0);
    prog[41] = enc_i(17, 17, 0, 18, op_jalr_code);
    prog[42] = enc_s(32'hc8, 2, 0);
    prog[43] = enc_s(32'hcc, 18, 0);
    prog[44] = enc_j(0, 0);
endtask

function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b110:  return a | b;
        3'b111:  return a & b;
        default: return 32'h0;
    endcase
endfunction

// Runs the program until its self loop, fills the expected store queues and final pc
function automatic int predict_stores();
    logic [31:0] x [0:31];
    logic [31:0] dm [0:63];
    logic [31:0] pc;
    logic [31:0] nxt;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ea;
    logic [31:0] res;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        wr;
    for (int r = 0; r < 32; r++) begin
        x[r] = 32'h0;
    end
    for (int w = 0; w < 64; w++) begin
        dm[w] = mem_init[w];
    end
    exp_addr.delete();
    exp_data.delete();
    exp_xfers = 0;
    pc = reset_pc;
    for (int step = 0; step < 1000; step++) begin
        ins   = prog[pc[7:2]];
        a     = x[ins[19:15]];
        b     = x[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nxt   = pc + 32'd4;
        res   = 32'h0;
        wr    = 1'b0;
        case (ins[6:0])
            7'h37: begin
                res = {ins[31:12], 12'h0};
                wr  = 1'b1;
            end
            7'h13: begin
                res = alu_model(ins[14:12], 1'b0, a, imm_i);
                wr  = 1'b1;
            end
            7'h33: begin
                res = alu_model(ins[14:12], ins[30], a, b);
                wr  = 1'b1;
            end
            7'h03: begin
                ea  = a + imm_i;
                res = dm[ea[7:2]];
                wr  = 1'b1;
                exp_xfers++;
            end
            7'h23: begin
                ea = a + imm_s;
                dm[ea[7:2]] = b;
                exp_addr.push_back(ea);
                exp_data.push_back(b);
                exp_xfers++;
            end
            7'h63: begin
                if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
                    nxt = pc + imm_b;
                end
            end
            7'h6f: begin
                res = pc + 32'd4;
                wr  = 1'b1;
                nxt = pc + imm_j;
            end
            7'h67: begin
                res = pc + 32'd4;
                wr  = 1'b1;
                nxt = (a + imm_i) & ~32'h1;
            end
            default: begin
            end
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            x[ins[11:7]] = res;
        end
        if (nxt == pc) begin
            break;
        end
        pc = nxt;
    end
    exp_final_pc = pc;
    return exp_addr.size();
endfunction

`endif

//--- verification/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb import core_pkg::*; ();

    logic        clk;
    logic        rst_n;
    logic [31:0] instr_addr;
    logic [31:0] instr_data;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // Slave memory and a copy of its start contents for the model
    logic [31:0] data_mem [0:63];
    logic [31:0] mem_init [0:63];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] got_addr [$];
    logic [31:0] got_data [$];
    logic [31:0] exp_final_pc;
    int          exp_xfers;
    int          xfer_count = 0;
    int          write_count = 0;
    int          checked = 0;
    int          errors = 0;
    int          wait_left;
    integer      seed;
    event        store_seen;

    `include "rv_ref_model.svh"

    localparam int timeout_cycles = prog_len * 50 * 4;

    rv_core_top rv_core_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .pstrb      (pstrb),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr)
    );

    // Instruction ROM
    assign instr_data = prog[instr_addr[7:2]];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_idle();
        if (instr_addr !== reset_pc) begin
            $display("[ERROR] instr_addr: got %h, expected %h", instr_addr, reset_pc);
            errors++;
        end
        if (psel !== 1'b0 || penable !== 1'b0) begin
            $display("[ERROR] psel/penable: got %h/%h, expected 0/0", psel, penable);
            errors++;
        end
    endtask

    task automatic check_store(input logic [31:0] a, input logic [31:0] d);
        if (checked >= exp_addr.size()) begin
            $display("Extra store to address %h that the program never makes", a);
            errors++;
        end else begin
            if (a !== exp_addr[checked]) begin
                $display("[ERROR] paddr: got %h, expected %h", a, exp_addr[checked]);
                errors++;
            end
            if (d !== exp_data[checked]) begin
                $display("[ERROR] pwdata: got %h, expected %h", d, exp_data[checked]);
                errors++;
            end
        end
        checked++;
    endtask

    // APB slave memory with 0 to 3 wait states
    initial begin
        pready    = 1'b0;
        prdata    = 32'h0;
        pslverr   = 1'b0;
        wait_left = 0;
        seed      = 32'hb227_5aba;
        for (int i = 0; i < 64; i++) begin
            mem_init[i] = $random(seed);
            data_mem[i] = mem_init[i];
        end
        forever begin
            @(posedge clk);
            #1;
            pready = 1'b0;
            if (psel && !penable) begin
                wait_left = $random(seed) & 3;
            end else if (psel && penable) begin
                if (wait_left > 0) begin
                    wait_left--;
                end else begin
                    pready = 1'b1;
                    if (pwrite) begin
                        data_mem[paddr[7:2]] = pwdata;
                    end else begin
                        prdata = data_mem[paddr[7:2]];
                    end
                end
            end
        end
    end

    // Transfer counter and write monitor
    always @(negedge clk) begin
        if (rst_n && psel && !penable) begin
            xfer_count++;
        end
        if (rst_n && psel && penable && pready && pwrite) begin
            write_count++;
            if (pstrb !== 4'hf) begin
                $display("[ERROR] pstrb: got %h, expected f", pstrb);
                errors++;
            end
            got_addr.push_back(paddr);
            got_data.push_back(pwdata);
            -> store_seen;
        end
    end

    initial begin
        forever begin
            @(store_seen);
            while (got_addr.size() > 0) begin
                check_store(got_addr.pop_front(), got_data.pop_front());
            end
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the program never reached its final loop",
                 timeout_cycles);
        $display("test failed");
        $finish;
    end

    initial begin
        logic [31:0] last_pc;
        int          stable;
        int          n_exp;
        load_program();
        rst_n = 1'b0;
        repeat (8) begin
            @(posedge clk);
            #1;
            check_idle();
        end
        rst_n = 1'b1;
        n_exp = predict_stores();
        $display("Reference model predicts %0d stores", n_exp);
        // Still at the first fetch in the cycle after reset
        @(negedge clk);
        check_idle();
        last_pc = instr_addr;
        stable  = 0;
        // Final self loop holds the pc with the bus idle
        while (stable < 4) begin
            @(posedge clk);
            #1;
            if (instr_addr === last_pc && !psel) begin
                stable++;
            end else begin
                stable = 0;
            end
            last_pc = instr_addr;
        end
        // The self loop address shows where the jumps really landed
        if (instr_addr !== exp_final_pc) begin
            $display("[ERROR] instr_addr: got %h, expected %h", instr_addr, exp_final_pc);
            errors++;
        end
        if (write_count != n_exp) begin
            $display("Store count mismatch: %0d APB writes seen, %0d expected",
                     write_count, n_exp);
            errors++;
        end
        if (xfer_count != exp_xfers) begin
            $display("Transfer count mismatch: %0d APB transfers seen, %0d expected",
                     xfer_count, exp_xfers);
            errors++;
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+verification
common/core_pkg.sv
common/data_req_if.sv
core/alu.sv
core/regfile.sv
core/control_decoder.sv
core/datapath.sv
verilog/fetch_unit.sv
verilog/apb_data_master.sv
verilog/rv_core_top.sv
verification/rv_core_tb.sv
